// File: src/rdp_consts.svh
// ****************************************
// Read datapath constants
// Widths, depths, latency range and the termination window of the
// half-rate read datapath with two read DQS groups
// ****************************************

`ifndef RDP_CONSTS_SVH
`define RDP_CONSTS_SVH

// Memory side, two read groups of four DQ each
`define RDP_MEM_DQ_WIDTH 8
`define RDP_READ_DQS_WIDTH 2
`define RDP_DQ_GROUP_WIDTH 4

// AFI side at half rate, four beats of all DQ per AFI cycle
`define RDP_AFI_RATE_RATIO 2
`define RDP_AFI_DATA_WIDTH 32
`define RDP_AFI_DQS_WIDTH 4

// Read-latency shift register length and the width of its selector
`define RDP_MAX_READ_LATENCY 16
`define RDP_LATENCY_COUNT_WIDTH 4

// Read-data FIFO, one flop bank per capture clock phase
`define RDP_READ_FIFO_DEPTH 8
`define RDP_READ_FIFO_ADDR_WIDTH 3

// Read latency in memory clocks; both OCT delays below derive from it
`define RDP_MEM_T_RL 11
// (T_RL - 4) / 2 for T_RL above 4, otherwise 0
`define RDP_OCT_ON_DELAY 3
// (T_RL + 6) / 2
`define RDP_OCT_OFF_DELAY 8

`endif

// File: src/rdp_pkg.sv
// ****************************************
// Read datapath types
// Vector types for the widths that carry a meaning in the datapath
// ****************************************

`default_nettype none

`include "rdp_consts.svh"

package rdp_pkg;

	// Read data on the AFI side, four beats of all DQ
	typedef logic [`RDP_AFI_DATA_WIDTH-1:0] afi_data_t;
	// Capture bus from the DDIO registers
	typedef logic [`RDP_AFI_DATA_WIDTH-1:0] ddio_data_t;
	// One group's four beats, beat 0 in the low nibble
	typedef logic [4*`RDP_DQ_GROUP_WIDTH-1:0] group_data_t;
	// One group's two beats captured in a single capture clock cycle
	typedef logic [2*`RDP_DQ_GROUP_WIDTH-1:0] ddio_group_t;
	// One bit per AFI phase
	typedef logic [`RDP_AFI_RATE_RATIO-1:0] afi_phase_t;
	// One bit per read DQS group
	typedef logic [`RDP_READ_DQS_WIDTH-1:0] dqs_group_vec_t;
	// Termination control, one bit per group and phase
	typedef logic [`RDP_AFI_DQS_WIDTH-1:0] oct_vec_t;
	typedef logic [`RDP_LATENCY_COUNT_WIDTH-1:0] latency_count_t;
	typedef logic [`RDP_READ_FIFO_ADDR_WIDTH-1:0] fifo_addr_t;

endpackage

`default_nettype wire

// File: src/rdp_flop_mem.sv
// ****************************************
// Dual-clock flop memory
// Eight words, written on every write clock edge, read combinationally
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_flop_mem (
	input  wire                  wr_clk_i,
	input  rdp_pkg::fifo_addr_t  wr_addr_i,
	input  rdp_pkg::ddio_group_t wr_data_i,
	input  rdp_pkg::fifo_addr_t  rd_addr_i,
	output rdp_pkg::ddio_group_t rd_data_o
);

	import rdp_pkg::*;

	ddio_group_t mem_q [`RDP_READ_FIFO_DEPTH];

	// The write clock runs only while the group captures, so every edge
	// carries a word
	always_ff @(posedge wr_clk_i)
	begin
		mem_q[wr_addr_i] <= wr_data_i;
	end

	// Read side belongs to the AFI domain, whose pointer trails the
	// writer by enough cycles for the word to settle
	assign rd_data_o = mem_q[rd_addr_i];

endmodule

`default_nettype wire

// File: src/rdp_read_fifo.sv
// ****************************************
// Read-data resynchronisation FIFO
// Writes one DQS group's captured data on a halved capture clock and
// reads it out in the AFI clock domain
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_read_fifo (
	input  wire                  pll_afi_clk_i,
	input  wire                  reset_n_afi_clk_i,
	input  wire                  read_capture_clk_i,
	input  wire                  seq_read_fifo_reset_i,
	input  wire                  read_enable_i,
	input  rdp_pkg::ddio_group_t ddio_group_i,
	output rdp_pkg::group_data_t group_data_o
);

	import rdp_pkg::*;

	logic        reset_n_write_side_q;
	logic        capture_clk_div2_q;
	logic        capture_clk_pos;
	logic        capture_clk_neg;
	fifo_addr_t  wr_addr_pos_q;
	fifo_addr_t  wr_addr_neg_q;
	fifo_addr_t  rd_addr_q;
	ddio_group_t rd_data_pos;
	ddio_group_t rd_data_neg;

	// ****************************************
	// Write-side reset
	// ****************************************
	// The sequencer request is registered in the AFI domain and then resets
	// the write side asynchronously; the capture clock is quiet while the
	// sequencer toggles this bit, so release needs no synchroniser
	always_ff @(posedge pll_afi_clk_i or negedge reset_n_afi_clk_i)
	begin
		if (!reset_n_afi_clk_i)
			reset_n_write_side_q <= 1'b0;
		else
			reset_n_write_side_q <= ~seq_read_fifo_reset_i;
	end

	// ****************************************
	// Capture clock halving
	// ****************************************
	// Two capture cycles make one AFI cycle of data, so the halved clock
	// writes one bank on each of its edges
	always_ff @(posedge read_capture_clk_i or negedge reset_n_write_side_q)
	begin
		if (!reset_n_write_side_q)
			capture_clk_div2_q <= 1'b0;
		else
			capture_clk_div2_q <= ~capture_clk_div2_q;
	end

	assign capture_clk_pos = capture_clk_div2_q;
	assign capture_clk_neg = ~capture_clk_div2_q;

	// ****************************************
	// Write pointers
	// ****************************************
	// Free-running; the depth is a power of two so the add wraps by itself
	always_ff @(posedge capture_clk_pos or negedge reset_n_write_side_q)
	begin
		if (!reset_n_write_side_q)
			wr_addr_pos_q <= '0;
		else
			wr_addr_pos_q <= wr_addr_pos_q + 1'b1;
	end

	always_ff @(posedge capture_clk_neg or negedge reset_n_write_side_q)
	begin
		if (!reset_n_write_side_q)
			wr_addr_neg_q <= '0;
		else
			wr_addr_neg_q <= wr_addr_neg_q + 1'b1;
	end

	// ****************************************
	// Read pointer
	// ****************************************
	// Steps once per AFI cycle of expected data, cleared with the write side
	always_ff @(posedge pll_afi_clk_i or negedge reset_n_afi_clk_i)
	begin
		if (!reset_n_afi_clk_i)
			rd_addr_q <= '0;
		else if (seq_read_fifo_reset_i)
			rd_addr_q <= '0;
		else if (read_enable_i)
			rd_addr_q <= rd_addr_q + 1'b1;
	end

	// Rising-edge bank holds beats 0 and 1
	rdp_flop_mem u_mem_pos (
		.wr_clk_i  (capture_clk_pos),
		.wr_addr_i (wr_addr_pos_q),
		.wr_data_i (ddio_group_i),
		.rd_addr_i (rd_addr_q),
		.rd_data_o (rd_data_pos)
	);

	// Falling-edge bank holds beats 2 and 3
	rdp_flop_mem u_mem_neg (
		.wr_clk_i  (capture_clk_neg),
		.wr_addr_i (wr_addr_neg_q),
		.wr_data_i (ddio_group_i),
		.rd_addr_i (rd_addr_q),
		.rd_data_o (rd_data_neg)
	);

	// Beat 0 in the low nibble
	assign group_data_o = {rd_data_neg, rd_data_pos};

endmodule

`default_nettype wire

// File: src/rdp_latency_ctrl.sv
// ****************************************
// Read-latency control
// Delays the read request by the calibrated latency to make the FIFO
// read enable and afi_rdata_valid
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_latency_ctrl (
	input  wire                     pll_afi_clk_i,
	input  wire                     reset_n_afi_clk_i,
	input  wire                     rdata_en_i,
	input  wire                     rdata_en_full_i,
	input  rdp_pkg::latency_count_t latency_count_i,
	output logic                    read_enable_o,
	output rdp_pkg::afi_phase_t     afi_rdata_valid_o
);

	import rdp_pkg::*;

	// Stage k holds the request sampled k+1 edges ago
	logic [`RDP_MAX_READ_LATENCY-1:0] en_shift_q;
	logic [`RDP_MAX_READ_LATENCY-1:0] full_shift_q;
	logic                             valid_sel_q;
	latency_count_t                   tap;

	// A request sampled at edge 0 sits in stage L-1 just before edge L,
	// so the registered selector rises right after edge L
	assign tap = latency_count_i - 1'b1;

	// ****************************************
	// Latency shifters
	// ****************************************
	always_ff @(posedge pll_afi_clk_i or negedge reset_n_afi_clk_i)
	begin
		if (!reset_n_afi_clk_i)
		begin
			en_shift_q <= '0;
			full_shift_q <= '0;
		end
		else
		begin
			en_shift_q <= {en_shift_q[`RDP_MAX_READ_LATENCY-2:0], rdata_en_i};
			full_shift_q <= {full_shift_q[`RDP_MAX_READ_LATENCY-2:0], rdata_en_full_i};
		end
	end

	// ****************************************
	// Selectors and valid output
	// ****************************************
	always_ff @(posedge pll_afi_clk_i or negedge reset_n_afi_clk_i)
	begin
		if (!reset_n_afi_clk_i)
		begin
			read_enable_o <= 1'b0;
			valid_sel_q <= 1'b0;
			afi_rdata_valid_o <= '0;
		end
		else
		begin
			// The full enable drives the FIFO read pointer
			read_enable_o <= full_shift_q[tap];
			valid_sel_q <= en_shift_q[tap];
			// One cycle behind the read enable, the same on both phases
			afi_rdata_valid_o <= {`RDP_AFI_RATE_RATIO{valid_sel_q}};
		end
	end

endmodule

`default_nettype wire

// File: src/rdp_oct_ctrl.sv
// ****************************************
// On-die termination control
// Forces termination off except in a window around each read burst
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_oct_ctrl (
	input  wire               pll_afi_clk_i,
	input  wire               reset_n_afi_clk_i,
	input  wire               rdata_en_full_i,
	output rdp_pkg::oct_vec_t force_oct_off_o
);

	// Stage k holds the enable sampled k+1 edges ago
	logic [`RDP_OCT_OFF_DELAY-1:0] en_hist_q;
	// Bit 0 is the enable at the current edge
	logic [`RDP_OCT_OFF_DELAY:0]   en_window;

	assign en_window = {en_hist_q, rdata_en_full_i};

	always_ff @(posedge pll_afi_clk_i or negedge reset_n_afi_clk_i)
	begin
		if (!reset_n_afi_clk_i)
		begin
			en_hist_q <= '0;
			force_oct_off_o <= '0;
		end
		else
		begin
			en_hist_q <= {en_hist_q[`RDP_OCT_OFF_DELAY-2:0], rdata_en_full_i};
			// Termination stays on while any request is inside the window
			force_oct_off_o <= {`RDP_AFI_DQS_WIDTH{
				~(|en_window[`RDP_OCT_OFF_DELAY:`RDP_OCT_ON_DELAY])}};
		end
	end

endmodule

`default_nettype wire

// File: src/rdp_read_datapath.sv
// ****************************************
// Read datapath top level
// Resynchronises captured read data into the AFI clock domain, times
// afi_rdata_valid from the read latency and controls termination
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_read_datapath (
	input  wire                     pll_afi_clk_i,
	input  wire                     reset_n_afi_clk_i,
	input  rdp_pkg::dqs_group_vec_t read_capture_clk_i,
	input  rdp_pkg::dqs_group_vec_t seq_read_fifo_reset_i,
	input  rdp_pkg::ddio_data_t     ddio_phy_dq_i,
	input  rdp_pkg::latency_count_t seq_read_latency_counter_i,
	input  rdp_pkg::afi_phase_t     afi_rdata_en_i,
	input  rdp_pkg::afi_phase_t     afi_rdata_en_full_i,
	output rdp_pkg::afi_data_t      afi_rdata_o,
	output rdp_pkg::afi_phase_t     afi_rdata_valid_o,
	output rdp_pkg::afi_data_t      phy_mux_read_fifo_q_o,
	output rdp_pkg::oct_vec_t       force_oct_off_o
);

	import rdp_pkg::*;

	// Each group owns a 16-bit field of the DDIO bus; its low byte holds the two
	// beats captured in one capture clock cycle
	localparam int unsigned DDIO_GROUP_STRIDE = `RDP_AFI_DATA_WIDTH / `RDP_READ_DQS_WIDTH;
	localparam int unsigned DDIO_GROUP_WIDTH = 2 * `RDP_DQ_GROUP_WIDTH;
	// Beats delivered per AFI cycle at half rate
	localparam int unsigned BEATS = 2 * `RDP_AFI_RATE_RATIO;

	logic        read_enable;
	group_data_t group_data [`RDP_READ_DQS_WIDTH];

	// The controller drives both phases alike in half rate, so phase 0
	// alone carries the request into the latency and termination logic
	rdp_latency_ctrl u_rdp_latency_ctrl (
		.pll_afi_clk_i     (pll_afi_clk_i),
		.reset_n_afi_clk_i (reset_n_afi_clk_i),
		.rdata_en_i        (afi_rdata_en_i[0]),
		.rdata_en_full_i   (afi_rdata_en_full_i[0]),
		.latency_count_i   (seq_read_latency_counter_i),
		.read_enable_o     (read_enable),
		.afi_rdata_valid_o (afi_rdata_valid_o)
	);

	rdp_oct_ctrl u_rdp_oct_ctrl (
		.pll_afi_clk_i     (pll_afi_clk_i),
		.reset_n_afi_clk_i (reset_n_afi_clk_i),
		.rdata_en_full_i   (afi_rdata_en_full_i[0]),
		.force_oct_off_o   (force_oct_off_o)
	);

	// ****************************************
	// Per-group FIFOs and data remapping
	// ****************************************
	for (genvar g = 0; g < `RDP_READ_DQS_WIDTH; g++)
	begin : g_group
		// One shared read enable serves every group
		rdp_read_fifo u_rdp_read_fifo (
			.pll_afi_clk_i         (pll_afi_clk_i),
			.reset_n_afi_clk_i     (reset_n_afi_clk_i),
			.read_capture_clk_i    (read_capture_clk_i[g]),
			.seq_read_fifo_reset_i (seq_read_fifo_reset_i[g]),
			.read_enable_i         (read_enable),
			.ddio_group_i          (ddio_phy_dq_i[DDIO_GROUP_STRIDE*g +: DDIO_GROUP_WIDTH]),
			.group_data_o          (group_data[g])
		);

		for (genvar t = 0; t < BEATS; t++)
		begin : g_beat
			// Time-major for the controller, groups side by side within a beat
			assign afi_rdata_o[`RDP_MEM_DQ_WIDTH*t + `RDP_DQ_GROUP_WIDTH*g +: `RDP_DQ_GROUP_WIDTH] =
				group_data[g][`RDP_DQ_GROUP_WIDTH*t +: `RDP_DQ_GROUP_WIDTH];
			// Group-major for the sequencer, beats side by side within a group
			assign phy_mux_read_fifo_q_o[4*`RDP_DQ_GROUP_WIDTH*g + `RDP_DQ_GROUP_WIDTH*t
				+: `RDP_DQ_GROUP_WIDTH] = group_data[g][`RDP_DQ_GROUP_WIDTH*t +: `RDP_DQ_GROUP_WIDTH];
		end
	end

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
// ****************************************
// Testbench clocks and reset
// AFI clock, two skewed capture clocks and the AFI reset
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic                    pll_afi_clk_o,
	output rdp_pkg::dqs_group_vec_t read_capture_clk_o,
	output logic                    reset_n_afi_clk_o
);

	logic capture_clk_0;
	logic capture_clk_1;

	assign read_capture_clk_o = {capture_clk_1, capture_clk_0};

	// 8 ns AFI clock
	initial
	begin
		pll_afi_clk_o = 1'b0;
		forever #4 pll_afi_clk_o = ~pll_afi_clk_o;
	end

	// Capture clocks at twice the AFI rate, group 1 a quarter period late
	initial
	begin
		capture_clk_0 = 1'b0;
		forever #2 capture_clk_0 = ~capture_clk_0;
	end

	initial
	begin
		capture_clk_1 = 1'b0;
		#1;
		forever #2 capture_clk_1 = ~capture_clk_1;
	end

	// Reset is released on the fourth rising edge, so that edge still resets
	initial
	begin
		reset_n_afi_clk_o = 1'b0;
		repeat (4) @(posedge pll_afi_clk_o);
		reset_n_afi_clk_o <= 1'b1;
	end

endmodule

`default_nettype wire

// File: test/rdp_read_datapath_checker.sv
// ****************************************
// Read datapath assertions
// Checks phase agreement of the valid and termination outputs and
// that no valid appears before the read latency allows it
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_read_datapath_checker (
	input wire                     pll_afi_clk_i,
	input wire                     reset_n_afi_clk_i,
	input rdp_pkg::latency_count_t seq_read_latency_counter_i,
	input rdp_pkg::afi_phase_t     afi_rdata_valid_i,
	input rdp_pkg::oct_vec_t       force_oct_off_i
);

	// Edges seen since reset release, saturating well above the longest latency
	logic [4:0] edge_count_q;

	always_ff @(posedge pll_afi_clk_i or negedge reset_n_afi_clk_i)
	begin
		if (!reset_n_afi_clk_i)
			edge_count_q <= '0;
		else if (edge_count_q != 5'd31)
			edge_count_q <= edge_count_q + 5'd1;
	end

	// Half rate drives both phases from one valid register
	valid_phases_equal: assert property (@(posedge pll_afi_clk_i)
		disable iff (!reset_n_afi_clk_i) afi_rdata_valid_i[0] == afi_rdata_valid_i[1])
		else $error("afi_rdata_valid phases disagree");

	// Every group and phase shares one termination window
	oct_bits_equal: assert property (@(posedge pll_afi_clk_i)
		disable iff (!reset_n_afi_clk_i)
		force_oct_off_i == {`RDP_AFI_DQS_WIDTH{force_oct_off_i[0]}})
		else $error("force_oct_off bits disagree");

	// A request at the first edge after reset is valid only after edge L+1
	no_early_valid: assert property (@(posedge pll_afi_clk_i)
		disable iff (!reset_n_afi_clk_i)
		(int'(edge_count_q) < int'(seq_read_latency_counter_i) + 2) |-> afi_rdata_valid_i == '0)
		else $error("afi_rdata_valid rose before the read latency allows");

endmodule

`default_nettype wire

// File: test/tb_read_datapath.sv
// ****************************************
// Read datapath testbench
// Directed tests of reset, latency, bursts, data remapping and the
// termination window
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module tb_read_datapath;

	import rdp_pkg::*;

	localparam int WAIT_LIMIT = 64;
	localparam int IDLE_CYCLES = 20;
	// Group 0 captures 0x21 and group 1 captures 0x87, the rest is filler
	localparam ddio_data_t DATA_PATTERN = 32'hEE87_DD21;

	logic           pll_afi_clk;
	logic           reset_n_afi_clk;
	dqs_group_vec_t read_capture_clk;
	dqs_group_vec_t seq_read_fifo_reset;
	ddio_data_t     ddio_phy_dq;
	latency_count_t seq_read_latency_counter;
	afi_phase_t     afi_rdata_en;
	afi_phase_t     afi_rdata_en_full;
	afi_data_t      afi_rdata;
	afi_phase_t     afi_rdata_valid;
	afi_data_t      phy_mux_read_fifo_q;
	oct_vec_t       force_oct_off;
	integer         seed;
	int             test_errors;
	int             total_errors;
	int             failed_tests;

	tb_clk_gen u_tb_clk_gen (
		.pll_afi_clk_o      (pll_afi_clk),
		.read_capture_clk_o (read_capture_clk),
		.reset_n_afi_clk_o  (reset_n_afi_clk)
	);

	rdp_read_datapath u_rdp_read_datapath (
		.pll_afi_clk_i              (pll_afi_clk),
		.reset_n_afi_clk_i          (reset_n_afi_clk),
		.read_capture_clk_i         (read_capture_clk),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset),
		.ddio_phy_dq_i              (ddio_phy_dq),
		.seq_read_latency_counter_i (seq_read_latency_counter),
		.afi_rdata_en_i             (afi_rdata_en),
		.afi_rdata_en_full_i        (afi_rdata_en_full),
		.afi_rdata_o                (afi_rdata),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q),
		.force_oct_off_o            (force_oct_off)
	);

	bind rdp_read_datapath rdp_read_datapath_checker u_rdp_read_datapath_checker (
		.pll_afi_clk_i              (pll_afi_clk_i),
		.reset_n_afi_clk_i          (reset_n_afi_clk_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.afi_rdata_valid_i          (afi_rdata_valid_o),
		.force_oct_off_i            (force_oct_off_o)
	);

	// ****************************************
	// Expected data
	// ****************************************
	// Each group's capture byte sits at the bottom of its 16-bit field; both banks
	// store the held byte, so even beats carry its low nibble and odd beats its high one
	function automatic logic [3:0] held_beat(ddio_data_t dq, int g, int t);
		return dq[16*g + 4*(t%2) +: 4];
	endfunction

	// Beat t of group g lands at bit 8t+4g
	function automatic afi_data_t time_major(ddio_data_t dq);
		afi_data_t word;
		word = '0;
		for (int t = 0; t < 4; t++)
			for (int g = 0; g < `RDP_READ_DQS_WIDTH; g++)
				word[8*t + 4*g +: 4] = held_beat(dq, g, t);
		return word;
	endfunction

	// Beat t of group g lands at bit 16g+4t
	function automatic afi_data_t group_major(ddio_data_t dq);
		afi_data_t word;
		word = '0;
		for (int t = 0; t < 4; t++)
			for (int g = 0; g < `RDP_READ_DQS_WIDTH; g++)
				word[16*g + 4*t +: 4] = held_beat(dq, g, t);
		return word;
	endfunction

	// ****************************************
	// Helpers
	// ****************************************
	// Inputs change 1 ns after the rising edge, outputs are settled by then
	task automatic next_cycle();
		@(posedge pll_afi_clk);
		#1;
	endtask

	task automatic wait_cycles(int n);
		repeat (n) next_cycle();
	endtask

	task automatic finish_test(string name);
		if (test_errors == 0)
			$display("%s: ok", name);
		else
		begin
			$display("%s: %0d errors", name, test_errors);
			failed_tests++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	// Steps until valid is high and counts the edges; -1 on timeout
	task automatic wait_for_valid(inout int edge_num);
		int waited;
		waited = 0;
		while (afi_rdata_valid[0] !== 1'b1 && waited < WAIT_LIMIT)
		begin
			next_cycle();
			edge_num++;
			waited++;
		end
		if (afi_rdata_valid[0] !== 1'b1)
		begin
			$display("Timed out waiting for afi_rdata_valid at time %0t", $time);
			test_errors++;
			edge_num = -1;
		end
	endtask

	// Issues n back-to-back reads at latency lat and checks the valid window;
	// with check_data set every valid word is compared with the held pattern
	task automatic read_burst(latency_count_t lat, int n, bit check_data);
		int edge_num;
		int words;
		seq_read_latency_counter = lat;
		wait_cycles(IDLE_CYCLES);
		afi_rdata_en = '1;
		afi_rdata_en_full = '1;
		wait_cycles(n);
		afi_rdata_en = '0;
		afi_rdata_en_full = '0;
		// Edge 0 sampled the first request and edge n-1 the last one
		edge_num = n - 1;
		wait_for_valid(edge_num);
		if (edge_num >= 0 && edge_num != lat + 1)
		begin
			$display("[ERROR] %0t: latency %0d gave valid after edge %0d, expected edge %0d",
				$time, lat, edge_num, lat + 1);
			test_errors++;
		end
		words = 0;
		while (afi_rdata_valid[0] === 1'b1 && words < WAIT_LIMIT)
		begin
			if (afi_rdata_valid !== 2'b11)
			begin
				$display("[ERROR] %0t: afi_rdata_valid is %b", $time, afi_rdata_valid);
				test_errors++;
			end
			if (check_data && afi_rdata !== time_major(DATA_PATTERN))
			begin
				$display("[ERROR] %0t: afi_rdata %h, expected %h", $time, afi_rdata,
					time_major(DATA_PATTERN));
				test_errors++;
			end
			if (check_data && phy_mux_read_fifo_q !== group_major(DATA_PATTERN))
			begin
				$display("[ERROR] %0t: phy_mux_read_fifo_q %h, expected %h", $time,
					phy_mux_read_fifo_q, group_major(DATA_PATTERN));
				test_errors++;
			end
			words++;
			next_cycle();
		end
		if (edge_num >= 0 && words != n)
		begin
			$display("[ERROR] %0t: %0d valid cycles, expected %0d", $time, words, n);
			test_errors++;
		end
	endtask

	// ****************************************
	// Tests
	// ****************************************
	task automatic test_reset();
		int waited;
		waited = 0;
		next_cycle();
		while (reset_n_afi_clk !== 1'b1 && waited < WAIT_LIMIT)
		begin
			if (afi_rdata_valid !== 2'b00 || force_oct_off !== 4'h0)
			begin
				$display("[ERROR] %0t: in reset valid %b oct %b, expected 00 and 0000",
					$time, afi_rdata_valid, force_oct_off);
				test_errors++;
			end
			next_cycle();
			waited++;
		end
		if (reset_n_afi_clk !== 1'b1)
		begin
			$display("Reset was never released");
			test_errors++;
		end
		// Termination is forced off at the first edge with no read in the window
		next_cycle();
		repeat (IDLE_CYCLES)
		begin
			if (afi_rdata_valid !== 2'b00 || force_oct_off !== 4'hF)
			begin
				$display("[ERROR] %0t: idle valid %b oct %b, expected 00 and 1111",
					$time, afi_rdata_valid, force_oct_off);
				test_errors++;
			end
			next_cycle();
		end
		finish_test("reset");
	endtask

	task automatic test_latency();
		latency_count_t lat;
		read_burst(4'd1, 1, 1'b0);
		read_burst(4'd15, 1, 1'b0);
		repeat (3)
		begin
			lat = latency_count_t'(1 + ({$random(seed)} % 15));
			read_burst(lat, 1, 1'b0);
		end
		finish_test("latency");
	endtask

	task automatic test_burst();
		read_burst(4'd8, 8, 1'b0);
		finish_test("burst");
	endtask

	task automatic test_data_mapping();
		ddio_phy_dq = DATA_PATTERN;
		seq_read_fifo_reset = '1;
		wait_cycles(2);
		seq_read_fifo_reset = '0;
		// The idle time inside the burst lets both banks fill with the pattern
		read_burst(4'd12, 8, 1'b1);
		finish_test("data mapping");
	endtask

	task automatic test_oct_window();
		oct_vec_t expected;
		wait_cycles(IDLE_CYCLES);
		afi_rdata_en_full = '1;
		next_cycle();
		afi_rdata_en_full = '0;
		// Now just after edge 0, which sampled the pulse
		for (int k = 0; k < 12; k++)
		begin
			expected = '1;
			if (k >= `RDP_OCT_ON_DELAY && k <= `RDP_OCT_OFF_DELAY)
				expected = '0;
			if (force_oct_off !== expected)
			begin
				$display("[ERROR] %0t: after edge %0d force_oct_off %b, expected %b",
					$time, k, force_oct_off, expected);
				test_errors++;
			end
			next_cycle();
		end
		finish_test("oct window");
	endtask

	// ****************************************
	// Sequence and watchdog
	// ****************************************
	initial
	begin
		seed = 37767;
		seq_read_fifo_reset = '0;
		ddio_phy_dq = '0;
		seq_read_latency_counter = 4'd4;
		afi_rdata_en = '0;
		afi_rdata_en_full = '0;
		test_errors = 0;
		total_errors = 0;
		failed_tests = 0;
		test_reset();
		test_latency();
		test_burst();
		test_data_mapping();
		test_oct_window();
		$display("Summary: 5 tests, %0d failed, %0d errors", failed_tests, total_errors);
		if (total_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		#50000;
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+src
src/rdp_pkg.sv
src/rdp_flop_mem.sv
src/rdp_read_fifo.sv
src/rdp_latency_ctrl.sv
src/rdp_oct_ctrl.sv
src/rdp_read_datapath.sv
test/tb_clk_gen.sv
test/rdp_read_datapath_checker.sv
test/tb_read_datapath.sv

// File: Makefile
# Verilator simulation of the read datapath
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_read_datapath
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# The run passes only when the testbench prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
